/* Bender.yml */
package:
  name: arith_core

sources:
  - include_dirs:
      - include
    files:
      - hw/arith_core_pkg.sv
      - hw/inst_decoder.sv
      - hw/regfile_pending.sv
      - hw/decode_issue.sv
      - hw/alu_pipe.sv
      - hw/result_unit.sv
      - hw/arith_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/arith_core_tb.sv

/* files.f */
+incdir+include
hw/arith_core_pkg.sv
hw/inst_decoder.sv
hw/regfile_pending.sv
hw/decode_issue.sv
hw/alu_pipe.sv
hw/result_unit.sv
hw/arith_core.sv
testbench/arith_core_tb.sv

/* hw/alu_pipe.sv */
// Two-stage ALU pipe
// Stage one computes the RV32I arithmetic result, stage two registers it
// on the way to the result unit; never stalls

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module alu_pipe import arith_core_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 iss_val,
  input  alu_op_e              iss_op,
  input  logic [31:0]          iss_op1,
  input  logic [31:0]          iss_op2,
  input  logic [4:0]           iss_waddr,
  input  logic [31:0]          iss_pc,
  input  logic [`SEQ_BITS-1:0] iss_seq_num,
  output logic                 ex_val,
  output logic [31:0]          ex_wdata,
  output logic [4:0]           ex_waddr,
  output logic [31:0]          ex_pc,
  output logic [`SEQ_BITS-1:0] ex_seq_num
);

  // ------------------------------
  // Stage one
  // ------------------------------

  logic [31:0]          result;
  logic [4:0]           shamt;
  logic                 s1_val;
  logic [31:0]          s1_result;
  logic [4:0]           s1_waddr;
  logic [31:0]          s1_pc;
  logic [`SEQ_BITS-1:0] s1_seq;

  assign shamt = iss_op2[4:0];

  always_comb begin
    case (iss_op)
      ALU_ADD:  result = iss_op1 + iss_op2;
      ALU_SUB:  result = iss_op1 - iss_op2;
      ALU_AND:  result = iss_op1 & iss_op2;
      ALU_OR:   result = iss_op1 | iss_op2;
      ALU_XOR:  result = iss_op1 ^ iss_op2;
      ALU_SLT:  result = {31'd0, $signed(iss_op1) < $signed(iss_op2)};
      ALU_SLTU: result = {31'd0, iss_op1 < iss_op2};
      ALU_SLL:  result = iss_op1 << shamt;
      ALU_SRL:  result = iss_op1 >> shamt;
      ALU_SRA:  result = $unsigned($signed(iss_op1) >>> shamt);
      default:  result = '0;
    endcase
  end

  // ------------------------------
  // Pipeline registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
      ex_val <= 1'b0;
    end else begin
      s1_val <= iss_val;
      ex_val <= s1_val;
    end
  end

  // Payload moves every cycle
  always_ff @(posedge clk) begin
    s1_result  <= result;
    s1_waddr   <= iss_waddr;
    s1_pc      <= iss_pc;
    s1_seq     <= iss_seq_num;
    ex_wdata   <= s1_result;
    ex_waddr   <= s1_waddr;
    ex_pc      <= s1_pc;
    ex_seq_num <= s1_seq;
  end

endmodule

`default_nettype wire

/* hw/arith_core.sv */
// Arithmetic core top
// Decode-issue, two-stage ALU pipe and result unit, fetch port in and
// retire port out

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module arith_core import arith_core_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch port
  input  logic                 f_val,
  output logic                 f_rdy,
  input  logic [31:0]          f_inst,
  input  logic [31:0]          f_pc,
  input  logic [`SEQ_BITS-1:0] f_seq_num,
  // Retire port
  output logic                 retire_val,
  input  logic                 retire_rdy,
  output logic [`SEQ_BITS-1:0] retire_seq_num,
  output logic [31:0]          retire_pc,
  output logic [4:0]           retire_waddr,
  output logic [31:0]          retire_wdata
);

  // ------------------------------
  // Inter-stage wires
  // ------------------------------

  logic                 iss_val;
  alu_op_e              iss_op;
  logic [31:0]          iss_op1;
  logic [31:0]          iss_op2;
  logic [4:0]           iss_waddr;
  logic [31:0]          iss_pc;
  logic [`SEQ_BITS-1:0] iss_seq_num;

  logic                 ex_val;
  logic [31:0]          ex_wdata;
  logic [4:0]           ex_waddr;
  logic [31:0]          ex_pc;
  logic [`SEQ_BITS-1:0] ex_seq_num;

  logic                 wb_val;
  logic [4:0]           wb_waddr;
  logic [31:0]          wb_wdata;
  logic                 credit_ret;

  decode_issue u_decode_issue (
    .clk         (clk),
    .rst         (rst),
    .f_val       (f_val),
    .f_rdy       (f_rdy),
    .f_inst      (f_inst),
    .f_pc        (f_pc),
    .f_seq_num   (f_seq_num),
    .iss_val     (iss_val),
    .iss_op      (iss_op),
    .iss_op1     (iss_op1),
    .iss_op2     (iss_op2),
    .iss_waddr   (iss_waddr),
    .iss_pc      (iss_pc),
    .iss_seq_num (iss_seq_num),
    .credit_ret  (credit_ret),
    .wb_val      (wb_val),
    .wb_waddr    (wb_waddr),
    .wb_wdata    (wb_wdata)
  );

  alu_pipe u_alu_pipe (
    .clk         (clk),
    .rst         (rst),
    .iss_val     (iss_val),
    .iss_op      (iss_op),
    .iss_op1     (iss_op1),
    .iss_op2     (iss_op2),
    .iss_waddr   (iss_waddr),
    .iss_pc      (iss_pc),
    .iss_seq_num (iss_seq_num),
    .ex_val      (ex_val),
    .ex_wdata    (ex_wdata),
    .ex_waddr    (ex_waddr),
    .ex_pc       (ex_pc),
    .ex_seq_num  (ex_seq_num)
  );

  result_unit u_result_unit (
    .clk            (clk),
    .rst            (rst),
    .ex_val         (ex_val),
    .ex_wdata       (ex_wdata),
    .ex_waddr       (ex_waddr),
    .ex_pc          (ex_pc),
    .ex_seq_num     (ex_seq_num),
    .wb_val         (wb_val),
    .wb_waddr       (wb_waddr),
    .wb_wdata       (wb_wdata),
    .credit_ret     (credit_ret),
    .retire_val     (retire_val),
    .retire_rdy     (retire_rdy),
    .retire_seq_num (retire_seq_num),
    .retire_pc      (retire_pc),
    .retire_waddr   (retire_waddr),
    .retire_wdata   (retire_wdata)
  );

endmodule

`default_nettype wire

/* hw/arith_core_pkg.sv */
// Arithmetic core shared types
// ALU operation encoding, RV32 opcodes and the instruction word views

`default_nettype none

package arith_core_pkg;

  // ------------------------------
  // Opcodes
  // ------------------------------

  // Register-register arithmetic
  localparam logic [6:0] OP     = 7'b0110011;
  // Register-immediate arithmetic
  localparam logic [6:0] OP_IMM = 7'b0010011;

  // ------------------------------
  // ALU operations
  // ------------------------------

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // ------------------------------
  // Instruction word
  // ------------------------------

  // R-type layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // I-type layout, imm12 overlays funct7 and rs2
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Same 32 bits, read either way by the decoder
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
  } inst_word_u;

endpackage

`default_nettype wire

/* hw/decode_issue.sv */
// Decode and issue stage
// Holds one fetched instruction, decodes it, reads operands and issues
// to the ALU pipe when sources are ready and a result slot is free

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module decode_issue import arith_core_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  // Fetch port
  input  logic                 f_val,
  output logic                 f_rdy,
  input  logic [31:0]          f_inst,
  input  logic [31:0]          f_pc,
  input  logic [`SEQ_BITS-1:0] f_seq_num,
  // Issue port
  output logic                 iss_val,
  output alu_op_e              iss_op,
  output logic [31:0]          iss_op1,
  output logic [31:0]          iss_op2,
  output logic [4:0]           iss_waddr,
  output logic [31:0]          iss_pc,
  output logic [`SEQ_BITS-1:0] iss_seq_num,
  // Credit return and writeback
  input  logic                 credit_ret,
  input  logic                 wb_val,
  input  logic [4:0]           wb_waddr,
  input  logic [31:0]          wb_wdata
);

  localparam int CREDIT_W = $clog2(`RESULT_DEPTH + 1);

  // ------------------------------
  // Instruction register
  // ------------------------------

  logic                 ir_val;
  inst_word_u           ir_inst;
  logic [31:0]          ir_pc;
  logic [`SEQ_BITS-1:0] ir_seq;

  // Empty, or emptying this cycle
  assign f_rdy = !ir_val || iss_val;

  always_ff @(posedge clk) begin
    if (rst) begin
      ir_val <= 1'b0;
    end else if (f_val && f_rdy) begin
      ir_val <= 1'b1;
    end else if (iss_val) begin
      ir_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_val && f_rdy) begin
      ir_inst <= f_inst;
      ir_pc   <= f_pc;
      ir_seq  <= f_seq_num;
    end
  end

  // ------------------------------
  // Decode and operand read
  // ------------------------------

  logic        dec_val;
  alu_op_e     dec_op;
  logic [4:0]  dec_raddr0;
  logic [4:0]  dec_raddr1;
  logic [4:0]  dec_waddr;
  logic        dec_use_imm;
  logic [31:0] dec_imm;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic        pend0;
  logic        pend1;

  inst_decoder u_decoder (
    .inst    (ir_inst),
    .val     (dec_val),
    .op      (dec_op),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .use_imm (dec_use_imm),
    .imm     (dec_imm)
  );

  // Reserve rd on issue, never x0
  regfile_pending u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .set_val  (iss_val && dec_waddr != '0),
    .set_addr (dec_waddr),
    .wen      (wb_val),
    .waddr    (wb_waddr),
    .wdata    (wb_wdata)
  );

  // ------------------------------
  // Stall logic
  // ------------------------------

  logic                prev_val;
  logic [4:0]          prev_waddr;
  logic                waw_hazard;
  logic [CREDIT_W-1:0] credits;

  // Back-to-back writes to one rd would let the older writeback clear
  // the younger reservation, so hold the second one a cycle
  assign waw_hazard = prev_val && (prev_waddr == dec_waddr) && (dec_waddr != '0);

  assign iss_val = ir_val && !pend0 && !pend1 && !waw_hazard && (credits != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      prev_val <= 1'b0;
    end else begin
      prev_val <= iss_val;
    end
    prev_waddr <= dec_waddr;
  end

  // One credit per free result buffer slot
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(`RESULT_DEPTH);
    end else if (iss_val && !credit_ret) begin
      credits <= credits - CREDIT_W'(1);
    end else if (credit_ret && !iss_val) begin
      credits <= credits + CREDIT_W'(1);
    end
  end

  // Issue payload
  assign iss_op      = dec_op;
  assign iss_op1     = rdata0;
  assign iss_op2     = dec_use_imm ? dec_imm : rdata1;
  assign iss_waddr   = dec_waddr;
  assign iss_pc      = ir_pc;
  assign iss_seq_num = ir_seq;

  credits_bounded: assert property (@(posedge clk) disable iff (rst)
    credits <= `RESULT_DEPTH);

  // Fetch side only delivers legal encodings
  ir_legal: assert property (@(posedge clk) disable iff (rst) ir_val |-> dec_val);

endmodule

`default_nettype wire

/* hw/inst_decoder.sv */
// Instruction decoder
// Maps an RV32I OP or OP_IMM word to ALU operation, register addresses
// and the sign-extended or shift-amount immediate

`timescale 1ns/10ps
`default_nettype none

module inst_decoder import arith_core_pkg::*; (
  input  inst_word_u  inst,
  output logic        val,
  output alu_op_e     op,
  output logic [4:0]  raddr0,
  output logic [4:0]  raddr1,
  output logic [4:0]  waddr,
  output logic        use_imm,
  output logic [31:0] imm
);

  // funct7 values, plain and sub/sra flavour
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  logic [6:0] f7;
  logic       f7_base;
  logic       f7_alt;

  // Upper seven bits, funct7 or the top of imm12
  assign f7      = inst.r_fmt.funct7;
  assign f7_base = (f7 == F7_BASE);
  assign f7_alt  = (f7 == F7_ALT);

  always_comb begin
    // Defaults follow the R-type fields
    val     = 1'b0;
    op      = ALU_ADD;
    use_imm = 1'b0;
    raddr0  = inst.r_fmt.rs1;
    raddr1  = inst.r_fmt.rs2;
    waddr   = inst.r_fmt.rd;
    imm     = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

    case (inst.r_fmt.opcode)
      OP: begin
        // Only add/sub and srl/sra allow the alt funct7
        case (inst.r_fmt.funct3)
          3'b000: begin op = f7_alt ? ALU_SUB : ALU_ADD; val = f7_base | f7_alt; end
          3'b001: begin op = ALU_SLL;  val = f7_base; end
          3'b010: begin op = ALU_SLT;  val = f7_base; end
          3'b011: begin op = ALU_SLTU; val = f7_base; end
          3'b100: begin op = ALU_XOR;  val = f7_base; end
          3'b101: begin op = f7_alt ? ALU_SRA : ALU_SRL; val = f7_base | f7_alt; end
          3'b110: begin op = ALU_OR;   val = f7_base; end
          default: begin op = ALU_AND; val = f7_base; end
        endcase
      end
      OP_IMM: begin
        use_imm = 1'b1;
        // rs2 bits belong to the immediate, point at x0 so no false stall
        raddr1  = '0;
        val     = 1'b1;
        case (inst.i_fmt.funct3)
          3'b000: op = ALU_ADD;
          3'b010: op = ALU_SLT;
          3'b011: op = ALU_SLTU;
          3'b100: op = ALU_XOR;
          3'b110: op = ALU_OR;
          3'b111: op = ALU_AND;
          // Shifts take a 5-bit amount
          3'b001: begin
            op  = ALU_SLL;
            imm = {27'd0, inst.i_fmt.imm12[4:0]};
            val = f7_base;
          end
          default: begin
            op  = f7_alt ? ALU_SRA : ALU_SRL;
            imm = {27'd0, inst.i_fmt.imm12[4:0]};
            val = f7_base | f7_alt;
          end
        endcase
      end
      default: val = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/regfile_pending.sv */
// Register file with pending scoreboard
// Two combinational reads, one write, x0 hardwired to zero, and a pending
// bit per register marking an outstanding write

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module regfile_pending (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr0,
  input  logic [4:0]  raddr1,
  output logic [31:0] rdata0,
  output logic [31:0] rdata1,
  output logic        pend0,
  output logic        pend1,
  input  logic        set_val,
  input  logic [4:0]  set_addr,
  input  logic        wen,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0]            regs [`REG_COUNT];
  logic [`REG_COUNT-1:0]  pending;

  // ------------------------------
  // Data array
  // ------------------------------

  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 reads as zero
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // ------------------------------
  // Pending scoreboard
  // ------------------------------

  // Set after clear, so a same-cycle overwrite stays pending
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wen) begin
        pending[waddr] <= 1'b0;
      end
      if (set_val) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

  assign pend0 = pending[raddr0];
  assign pend1 = pending[raddr1];

  // Issue side must never reserve x0
  x0_never_pending: assert property (@(posedge clk) disable iff (rst) !pending[0]);

endmodule

`default_nettype wire

/* hw/result_unit.sv */
// Result unit
// Writes ALU results back to the register file, buffers them in order
// and presents the oldest one on the retire port

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module result_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 ex_val,
  input  logic [31:0]          ex_wdata,
  input  logic [4:0]           ex_waddr,
  input  logic [31:0]          ex_pc,
  input  logic [`SEQ_BITS-1:0] ex_seq_num,
  output logic                 wb_val,
  output logic [4:0]           wb_waddr,
  output logic [31:0]          wb_wdata,
  output logic                 credit_ret,
  output logic                 retire_val,
  input  logic                 retire_rdy,
  output logic [`SEQ_BITS-1:0] retire_seq_num,
  output logic [31:0]          retire_pc,
  output logic [4:0]           retire_waddr,
  output logic [31:0]          retire_wdata
);

  localparam int PTR_W = $clog2(`RESULT_DEPTH);
  localparam int CNT_W = $clog2(`RESULT_DEPTH + 1);

  logic [31:0]          buf_pc    [`RESULT_DEPTH];
  logic [`SEQ_BITS-1:0] buf_seq   [`RESULT_DEPTH];
  logic [4:0]           buf_waddr [`RESULT_DEPTH];
  logic [31:0]          buf_wdata [`RESULT_DEPTH];
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;
  logic                 pop;

  // Writeback in the same cycle the result is buffered
  assign wb_val   = ex_val;
  assign wb_waddr = ex_waddr;
  assign wb_wdata = ex_wdata;

  // ------------------------------
  // Result FIFO
  // ------------------------------

  assign retire_val = (count != '0);
  assign pop        = retire_val && retire_rdy;
  assign credit_ret = pop;

  always_ff @(posedge clk) begin
    if (ex_val) begin
      buf_pc[wr_ptr]    <= ex_pc;
      buf_seq[wr_ptr]   <= ex_seq_num;
      buf_waddr[wr_ptr] <= ex_waddr;
      buf_wdata[wr_ptr] <= ex_wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ex_val) begin
        wr_ptr <= (wr_ptr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`RESULT_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      if (ex_val && !pop) begin
        count <= count + CNT_W'(1);
      end else if (pop && !ex_val) begin
        count <= count - CNT_W'(1);
      end
    end
  end

  // Oldest entry on the retire port
  assign retire_seq_num = buf_seq[rd_ptr];
  assign retire_pc      = buf_pc[rd_ptr];
  assign retire_waddr   = buf_waddr[rd_ptr];
  assign retire_wdata   = buf_wdata[rd_ptr];

  // Credits upstream must keep the buffer from overflowing
  no_overflow: assert property (@(posedge clk) disable iff (rst)
    ex_val |-> count != CNT_W'(`RESULT_DEPTH));

endmodule

`default_nettype wire

/* include/arith_core_macros.svh */
// Arithmetic core sizing constants
// Register count, sequence tag width, result buffer depth and ALU latency

`ifndef ARITH_CORE_MACROS_SVH
`define ARITH_CORE_MACROS_SVH

// ------------------------------
// Architectural state
// ------------------------------

// RV32 integer registers, x0 included
`define REG_COUNT 32

// ------------------------------
// Pipeline sizing
// ------------------------------

// Width of the in-order sequence tag
`define SEQ_BITS 8

// Result buffer entries, also the credit count after reset
`define RESULT_DEPTH 4

// Issue to buffer entry, in cycles
`define ALU_LATENCY 2

`endif // ARITH_CORE_MACROS_SVH

/* testbench/arith_core_tb.sv */
// Arithmetic core testbench
// Directed tests checked against an RV32I reference model, with in-order
// retire checks, retire back-pressure and a cycle-budget watchdog

`timescale 1ns/10ps
`default_nettype none

`include "arith_core_macros.svh"

module arith_core_tb import arith_core_pkg::*; ();

  // Instructions sent by each test, in run order
  localparam int INSTR_TOTAL     = 20 + 18 + 10 + 5 + 10 + 40;
  localparam int WATCHDOG_CYCLES = INSTR_TOTAL * (`ALU_LATENCY + 8) + 200;

  // Retire ready modes
  localparam int RDY_ON     = 0;
  localparam int RDY_HOLD   = 1;
  localparam int RDY_RANDOM = 2;

  logic                 clk;
  logic                 rst;
  logic                 f_val;
  logic                 f_rdy;
  logic [31:0]          f_inst;
  logic [31:0]          f_pc;
  logic [`SEQ_BITS-1:0] f_seq_num;
  logic                 retire_val;
  logic                 retire_rdy;
  logic [`SEQ_BITS-1:0] retire_seq_num;
  logic [31:0]          retire_pc;
  logic [4:0]           retire_waddr;
  logic [31:0]          retire_wdata;

  arith_core DUT (
    .clk            (clk),
    .rst            (rst),
    .f_val          (f_val),
    .f_rdy          (f_rdy),
    .f_inst         (f_inst),
    .f_pc           (f_pc),
    .f_seq_num      (f_seq_num),
    .retire_val     (retire_val),
    .retire_rdy     (retire_rdy),
    .retire_seq_num (retire_seq_num),
    .retire_pc      (retire_pc),
    .retire_waddr   (retire_waddr),
    .retire_wdata   (retire_wdata)
  );

  always #2 clk = ~clk;

  // ------------------------------
  // Reference state
  // ------------------------------

  logic [31:0]          ref_regs [`REG_COUNT];
  logic [`SEQ_BITS-1:0] exp_seq [$];
  logic [31:0]          exp_pc [$];
  logic [4:0]           exp_waddr [$];
  logic [31:0]          exp_wdata [$];
  logic [`SEQ_BITS-1:0] next_seq;
  logic [255:0]         rdy_bits;
  int unsigned          rdy_idx;
  int                   rdy_mode;
  string                cur_test;
  int                   test_err_start;
  int                   err_count;
  int                   check_count;
  int                   test_count;
  int                   retired_total;

  task automatic check_word(input string field, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, field, exp, act);
    end
  endtask

  task automatic check_seq(input string field, input logic [`SEQ_BITS-1:0] exp,
                           input logic [`SEQ_BITS-1:0] act);
    check_count++;
    if (act !== exp) begin
      err_count++;
      $display("Mismatch in %s, %s: expected %0d, actual %0d", cur_test, field, exp, act);
    end
  endtask

  // RV32I semantics for OP and OP_IMM
  function automatic logic [31:0] ref_result(input logic [31:0] inst);
    logic [31:0] a;
    logic [31:0] b;
    logic        is_imm;
    logic        alt;
    is_imm = (inst[6:0] == OP_IMM);
    alt    = inst[30];
    a      = ref_regs[inst[19:15]];
    b      = is_imm ? {{20{inst[31]}}, inst[31:20]} : ref_regs[inst[24:20]];
    case (inst[14:12])
      3'd0: ref_result = (alt && !is_imm) ? a - b : a + b;
      3'd1: ref_result = a << b[4:0];
      3'd2: ref_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: ref_result = (a < b) ? 32'd1 : 32'd0;
      3'd4: ref_result = a ^ b;
      3'd5: begin
        if (alt) ref_result = $signed(a) >>> b[4:0];
        else ref_result = a >> b[4:0];
      end
      3'd6: ref_result = a | b;
      default: ref_result = a & b;
    endcase
  endfunction

  // ------------------------------
  // Encoders
  // ------------------------------

  // 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 sltu, 7 sll, 8 srl, 9 sra
  function automatic logic [31:0] enc_r(input int k, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [2:0] f3;
    logic [6:0] f7;
    f7 = (k == 1 || k == 9) ? 7'b0100000 : 7'b0000000;
    case (k)
      0, 1:    f3 = 3'd0;
      2:       f3 = 3'd7;
      3:       f3 = 3'd6;
      4:       f3 = 3'd4;
      5:       f3 = 3'd2;
      6:       f3 = 3'd3;
      7:       f3 = 3'd1;
      default: f3 = 3'd5;
    endcase
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  // 0 addi, 1 slti, 2 sltiu, 3 xori, 4 ori, 5 andi, 6 slli, 7 srli, 8 srai
  function automatic logic [31:0] enc_i(input int k, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    logic [2:0]  f3;
    logic [11:0] imm_f;
    case (k)
      0:       f3 = 3'd0;
      1:       f3 = 3'd2;
      2:       f3 = 3'd3;
      3:       f3 = 3'd4;
      4:       f3 = 3'd6;
      5:       f3 = 3'd7;
      6:       f3 = 3'd1;
      default: f3 = 3'd5;
    endcase
    // Shifts carry funct7 above a 5-bit amount
    if (k >= 6) imm_f = {(k == 8) ? 7'b0100000 : 7'b0000000, imm[4:0]};
    else imm_f = imm;
    return {imm_f, rs1, f3, rd, OP_IMM};
  endfunction

  // ------------------------------
  // Fetch driver and retire monitor
  // ------------------------------

  // Expected retire recorded in program order, then offered until taken
  task automatic send(input logic [31:0] inst);
    logic [31:0] res;
    res = ref_result(inst);
    exp_seq.push_back(next_seq);
    exp_pc.push_back(32'(next_seq) * 4);
    exp_waddr.push_back(inst[11:7]);
    exp_wdata.push_back(res);
    if (inst[11:7] != 5'd0) ref_regs[inst[11:7]] = res;
    @(negedge clk);
    f_val     = 1'b1;
    f_inst    = inst;
    f_pc      = 32'(next_seq) * 4;
    f_seq_num = next_seq;
    next_seq++;
    #1;
    while (!f_rdy) begin
      @(negedge clk);
      #1;
    end
  endtask

  task automatic fetch_idle();
    @(negedge clk);
    f_val = 1'b0;
  endtask

  task automatic check_retire();
    if (exp_seq.size() == 0) begin
      err_count++;
      $display("Error in %s: retire of seq %0d with nothing outstanding", cur_test,
               retire_seq_num);
    end else begin
      check_seq("seq", exp_seq.pop_front(), retire_seq_num);
      check_word("pc", exp_pc.pop_front(), retire_pc);
      check_word("waddr", exp_waddr.pop_front(), retire_waddr);
      check_word("wdata", exp_wdata.pop_front(), retire_wdata);
    end
    retired_total++;
  endtask

  // Ready changes on the falling edge, handshake sampled mid low phase
  always begin
    @(negedge clk);
    case (rdy_mode)
      RDY_ON:   retire_rdy = 1'b1;
      RDY_HOLD: retire_rdy = 1'b0;
      default: begin
        retire_rdy = rdy_bits[rdy_idx[7:0]];
        rdy_idx++;
      end
    endcase
    #1;
    if (!rst && retire_val && retire_rdy) check_retire();
  end

  // ------------------------------
  // Tests
  // ------------------------------

  task automatic start_test(input string name, input int mode);
    @(negedge clk);
    #1;
    cur_test       = name;
    test_err_start = err_count;
    rdy_mode       = mode;
  endtask

  task automatic finish_test();
    fetch_idle();
    while (exp_seq.size() != 0) @(negedge clk);
    test_count++;
    $display("Test %s finished, %0d errors", cur_test, err_count - test_err_start);
  endtask

  // Shift and xor random bits in to fill all 32 bits
  task automatic load_random(input logic [4:0] rd);
    send(enc_i(0, rd, 5'd0, 12'($urandom)));
    send(enc_i(6, rd, rd, 12'd11));
    send(enc_i(3, rd, rd, 12'($urandom)));
    send(enc_i(6, rd, rd, 12'd11));
    send(enc_i(3, rd, rd, 12'($urandom)));
  endtask

  task automatic test_reg_ops();
    start_test("reg_ops", RDY_ON);
    load_random(5'd1);
    load_random(5'd2);
    for (int k = 0; k < 10; k++) send(enc_r(k, 5'(k + 3), 5'd1, 5'd2));
    finish_test();
  endtask

  task automatic test_imm_ops();
    start_test("imm_ops", RDY_ON);
    load_random(5'd5);
    // Sets bits 31 down to 11, so x5 goes negative
    send(enc_i(4, 5'd5, 5'd5, 12'h800));
    send(enc_i(0, 5'd6, 5'd5, 12'hfff));
    send(enc_i(3, 5'd7, 5'd5, 12'h9ab));
    send(enc_i(5, 5'd8, 5'd5, 12'hf0f));
    send(enc_i(4, 5'd9, 5'd0, 12'h801));
    send(enc_i(1, 5'd10, 5'd5, 12'hffd));
    send(enc_i(2, 5'd11, 5'd5, 12'hfff));
    send(enc_i(6, 5'd12, 5'd5, 12'd7));
    // srl and sra part ways on a negative source
    send(enc_i(7, 5'd13, 5'd5, 12'd13));
    send(enc_i(8, 5'd14, 5'd5, 12'd13));
    send(enc_i(7, 5'd15, 5'd5, 12'd31));
    send(enc_i(8, 5'd16, 5'd5, 12'd31));
    send(enc_i(0, 5'd17, 5'd0, 12'h800));
    finish_test();
  endtask

  task automatic test_dep_chain();
    start_test("dep_chain", RDY_ON);
    send(enc_i(0, 5'd20, 5'd0, 12'd3));
    for (int k = 0; k < 8; k++) begin
      case (k % 3)
        0: send(enc_r(0, 5'd20, 5'd20, 5'd20));
        1: send(enc_i(0, 5'd20, 5'd20, 12'hff9));
        default: send(enc_r(4, 5'd20, 5'd20, 5'd1));
      endcase
    end
    send(enc_r(1, 5'd21, 5'd20, 5'd2));
    finish_test();
  endtask

  task automatic test_x0_writes();
    start_test("x0_writes", RDY_ON);
    send(enc_i(0, 5'd0, 5'd0, 12'd55));
    send(enc_r(0, 5'd0, 5'd1, 5'd2));
    send(enc_r(0, 5'd22, 5'd0, 5'd0));
    send(enc_i(0, 5'd23, 5'd0, 12'd7));
    send(enc_r(3, 5'd24, 5'd0, 5'd1));
    finish_test();
  endtask

  task automatic test_retire_hold();
    start_test("retire_hold", RDY_HOLD);
    fork
      begin
        for (int k = 0; k < 10; k++) send(enc_i(0, 5'(k + 1), 5'(k + 2), 12'($urandom)));
        fetch_idle();
      end
    join_none
    repeat (40) @(negedge clk);
    #1;
    // Buffer and credits exhausted by now
    if (f_rdy) begin
      err_count++;
      $display("Error in %s: fetch still ready while retire is held off", cur_test);
    end
    // Oldest buffered result waits at the port
    if (!retire_val) begin
      err_count++;
      $display("Error in %s: retire port idle while results are buffered", cur_test);
    end
    check_seq("oldest held", exp_seq[0], retire_seq_num);
    rdy_mode = RDY_ON;
    wait fork;
    finish_test();
  endtask

  task automatic test_random_stream();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    start_test("random_stream", RDY_RANDOM);
    // Registers x0 to x12 all hold known values by now
    for (int n = 0; n < 40; n++) begin
      kind = $urandom_range(0, 18);
      rd   = 5'($urandom_range(0, 12));
      rs1  = 5'($urandom_range(0, 12));
      rs2  = 5'($urandom_range(0, 12));
      if (kind < 10) send(enc_r(kind, rd, rs1, rs2));
      else send(enc_i(kind - 10, rd, rs1, 12'($urandom)));
    end
    finish_test();
  endtask

  // ------------------------------
  // Run control
  // ------------------------------

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h57d5));
    clk           = 1'b0;
    rst           = 1'b1;
    f_val         = 1'b0;
    f_inst        = '0;
    f_pc          = '0;
    f_seq_num     = '0;
    retire_rdy    = 1'b0;
    rdy_mode      = RDY_ON;
    rdy_idx       = 0;
    next_seq      = '0;
    err_count     = 0;
    check_count   = 0;
    test_count    = 0;
    retired_total = 0;
    cur_test      = "reset";
    for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;
    for (int i = 0; i < 8; i++) rdy_bits[i*32 +: 32] = $urandom;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reg_ops();
    test_imm_ops();
    test_dep_chain();
    test_x0_writes();
    test_retire_hold();
    test_random_stream();

    $display("Tests: %0d, checks: %0d, retired: %0d, errors: %0d", test_count, check_count,
             retired_total, err_count);
    if (err_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
